//--- Bender.yml
package:
  name: memory_game

sources:
  - gamePkg.sv
  - boardCtrlIf.sv
  - keyDecoder.sv
  - revealTimer.sv
  - tileBoard.sv
  - gameControl.sv
  - memoryGameTop.sv
  - target: test
    files:
      - tbMemoryGame.sv

//--- boardCtrlIf.sv
`timescale 1ns/1ps

interface boardCtrlIf;

	// from the game control
	logic takeFirst;
	logic takeSecond;
	logic resolve;
	logic clearAll;

	// from the tile board
	logic firstTaken;
	logic secondTaken;
	logic allMatched;

	modport control (
		output takeFirst,
		output takeSecond,
		output resolve,
		output clearAll,
		input  firstTaken,
		input  secondTaken,
		input  allMatched
	);

	modport board (
		input  takeFirst,
		input  takeSecond,
		input  resolve,
		input  clearAll,
		output firstTaken,
		output secondTaken,
		output allMatched
	);

endinterface

//--- gameControl.sv
`timescale 1ns/1ps

module gameControl import gamePkg::*; #(
	parameter int WaitCycles = 25000000,
	parameter int HoldCycles = 50000000
) (
	input  logic Clock,
	input  logic rstN,
	input  logic gameEnable,
	input  logic quit,
	boardCtrlIf.control boardBus,
	output logic timerStart,
	output logic [31:0] timerCycles,
	input  logic timerDone,
	output logic gameOver
);

	logic [2:0] state;
	logic [2:0] nextState;

	always_comb
	begin
		nextState = state;
		case (state)
			NotInGame:
			begin
				if (gameEnable)
					nextState = Idle;
			end
			Idle:
			begin
				// the last resolve may have filled the board
				if (boardBus.allMatched)
					nextState = GameOver;
				else if (boardBus.firstTaken)
					nextState = Waiting;
			end
			Waiting:
			begin
				if (timerDone)
					nextState = OneTile;
			end
			OneTile:
			begin
				if (boardBus.secondTaken)
					nextState = TwoTile;
			end
			TwoTile:
			begin
				if (timerDone)
					nextState = Idle;
			end
			GameOver:
			begin
				nextState = GameOver;
			end
			default:
			begin
				nextState = NotInGame;
			end
		endcase
		if (quit || !gameEnable)
			nextState = NotInGame;
	end

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			state <= NotInGame;
			timerStart <= 1'b0;
		end
		else
		begin
			state <= nextState;
			timerStart <= (nextState != state)
				&& (nextState == Waiting || nextState == TwoTile);
		end
	end

	// the count is only sampled in the first cycle of either delay state
	assign timerCycles = (state == TwoTile) ? 32'(HoldCycles) : 32'(WaitCycles);

	assign boardBus.takeFirst = (state == Idle);
	assign boardBus.takeSecond = (state == OneTile);
	assign boardBus.clearAll = (state == NotInGame);
	assign boardBus.resolve = (state == TwoTile) && timerDone;
	assign gameOver = (state == GameOver);

	// no stale done may cut the hold short on its first cycle
	resolveInTwoTile: assert property (
		@(posedge Clock) disable iff (!rstN)
		boardBus.resolve |-> $past(state == TwoTile)
	);

endmodule

//--- gamePkg.sv
package gamePkg;

	localparam int TileCount = 10;
	localparam int TileIdxW = 4;
	localparam int ColorW = 4;
	localparam int ScoreW = 8;

	// shown on a color digit when no tile is face up
	localparam logic [ColorW-1:0] NoColor = 4'hF;

	localparam logic [7:0] BreakCode = 8'hF0;

	// keys 1 2 3 4 Q W E R A S, tile 0 first
	localparam logic [7:0] KeyCodes [TileCount] = '{
		8'h16, 8'h1E, 8'h26, 8'h25, 8'h15,
		8'h1D, 8'h24, 8'h2D, 8'h1C, 8'h1B
	};

	// five color pairs spread over the board
	localparam logic [ColorW-1:0] TileColors [TileCount] = '{
		4'h3, 4'h5, 4'h1, 4'h1, 4'h2,
		4'h7, 4'h5, 4'h7, 4'h2, 4'h3
	};

	// game states
	localparam logic [2:0] Idle = 3'b000;
	localparam logic [2:0] OneTile = 3'b001;
	localparam logic [2:0] Waiting = 3'b010;
	localparam logic [2:0] TwoTile = 3'b011;
	localparam logic [2:0] GameOver = 3'b100;
	localparam logic [2:0] NotInGame = 3'b101;

endpackage

//--- keyDecoder.sv
`timescale 1ns/1ps

module keyDecoder import gamePkg::*; (
	input  logic Clock,
	input  logic rstN,
	input  logic [7:0] keyCode,
	input  logic keyStrobe,
	output logic pickValid,
	output logic [TileIdxW-1:0] pickIdx
);

	logic breakSeen;
	logic codeHit;
	logic [TileIdxW-1:0] codeIdx;

	// table lookup of the current byte
	always_comb
	begin
		codeHit = 1'b0;
		codeIdx = '0;
		for (int i = 0; i < TileCount; i++)
		begin
			if (keyCode == KeyCodes[i])
			begin
				codeHit = 1'b1;
				codeIdx = TileIdxW'(i);
			end
		end
	end

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			breakSeen <= 1'b0;
			pickValid <= 1'b0;
		end
		else
		begin
			pickValid <= 1'b0;
			if (keyStrobe)
			begin
				// the byte after F0 names the released key
				if (breakSeen)
					breakSeen <= 1'b0;
				else if (keyCode == BreakCode)
					breakSeen <= 1'b1;
				else if (codeHit)
					pickValid <= 1'b1;
			end
		end
	end

	always_ff @(posedge Clock)
	begin
		if (keyStrobe && codeHit)
			pickIdx <= codeIdx;
	end

endmodule

//--- memoryGameTop.sv
`timescale 1ns/1ps

module memoryGameTop import gamePkg::*; #(
	parameter int WaitCycles = 25000000,
	parameter int HoldCycles = 50000000
) (
	input  logic Clock,
	input  logic rstN,
	input  logic gameEnable,
	input  logic quit,
	input  logic [7:0] keyCode,
	input  logic keyStrobe,
	output logic [TileCount-1:0] tileLeds,
	output logic [ColorW-1:0] firstColor,
	output logic [ColorW-1:0] secondColor,
	output logic [ScoreW-1:0] score,
	output logic gameOver
);

	logic pickValid;
	logic [TileIdxW-1:0] pickIdx;
	logic timerStart;
	logic [31:0] timerCycles;
	logic timerDone;

	boardCtrlIf boardBus ();

	keyDecoder uKeyDecoder (
		.Clock     (Clock),
		.rstN      (rstN),
		.keyCode   (keyCode),
		.keyStrobe (keyStrobe),
		.pickValid (pickValid),
		.pickIdx   (pickIdx)
	);

	tileBoard uTileBoard (
		.Clock       (Clock),
		.rstN        (rstN),
		.pickValid   (pickValid),
		.pickIdx     (pickIdx),
		.boardBus    (boardBus.board),
		.tileLeds    (tileLeds),
		.firstColor  (firstColor),
		.secondColor (secondColor),
		.score       (score)
	);

	gameControl #(
		.WaitCycles (WaitCycles),
		.HoldCycles (HoldCycles)
	) uGameControl (
		.Clock       (Clock),
		.rstN        (rstN),
		.gameEnable  (gameEnable),
		.quit        (quit),
		.boardBus    (boardBus.control),
		.timerStart  (timerStart),
		.timerCycles (timerCycles),
		.timerDone   (timerDone),
		.gameOver    (gameOver)
	);

	revealTimer uRevealTimer (
		.Clock       (Clock),
		.rstN        (rstN),
		.timerStart  (timerStart),
		.timerCycles (timerCycles),
		.timerDone   (timerDone)
	);

endmodule

//--- revealTimer.sv
`timescale 1ns/1ps

module revealTimer (
	input  logic Clock,
	input  logic rstN,
	input  logic timerStart,
	input  logic [31:0] timerCycles,
	output logic timerDone
);

	logic [31:0] count;
	logic busy;

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			count <= '0;
			busy <= 1'b0;
		end
		else if (timerStart)
		begin
			// a new start always reloads, even mid count
			count <= timerCycles;
			busy <= 1'b1;
		end
		else if (busy)
		begin
			if (count == '0)
				busy <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	assign timerDone = busy && (count == '0);

	doneSingleCycle: assert property (
		@(posedge Clock) disable iff (!rstN)
		timerDone |=> !timerDone
	);

endmodule

//--- tbMemoryGame.sv
`timescale 1ns/1ps

module tbMemoryGame import gamePkg::*; ();

	localparam int WaitCycles = 4;
	localparam int HoldCycles = 6;
	localparam int SettleCycles = 20;
	localparam int RandomRounds = 300;
	localparam int ScriptSteps = 32;
	// a random round sends at most two bytes
	localparam int MaxSteps = ScriptSteps + 2 * RandomRounds;
	localparam int WatchdogNs = MaxSteps * SettleCycles * 10 * 2;

	logic Clock = 1'b0;
	logic rstN;
	logic gameEnable;
	logic quit;
	logic [7:0] keyCode;
	logic keyStrobe;
	logic [TileCount-1:0] tileLeds;
	logic [ColorW-1:0] firstColor;
	logic [ColorW-1:0] secondColor;
	logic [ScoreW-1:0] score;
	logic gameOver;

	integer seed = 32'h2259_ff97;

	// reference model of the game as seen after every settle window
	logic modelBreak;
	logic [2:0] modelPhase;
	logic [TileCount-1:0] modelMatched;
	int modelFirstIdx;
	logic modelFirstHeld;
	logic [ColorW-1:0] modelFirstColor;
	logic [ColorW-1:0] modelRevealColor;
	logic [ScoreW-1:0] modelScore;

	memoryGameTop #(
		.WaitCycles (WaitCycles),
		.HoldCycles (HoldCycles)
	) u_dut (
		.Clock       (Clock),
		.rstN        (rstN),
		.gameEnable  (gameEnable),
		.quit        (quit),
		.keyCode     (keyCode),
		.keyStrobe   (keyStrobe),
		.tileLeds    (tileLeds),
		.firstColor  (firstColor),
		.secondColor (secondColor),
		.score       (score),
		.gameOver    (gameOver)
	);

	always #5 Clock = ~Clock;

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s expected %0h actual %0h", testName, expected, actual);
			$display("tests failed");
			$fatal(1, "mismatch in %s", testName);
		end
	endtask

	task automatic compareOutputs(input string testName);
		logic [TileCount-1:0] expLeds;
		expLeds = modelMatched;
		if (modelFirstHeld)
			expLeds[modelFirstIdx] = 1'b1;
		checkValue({testName, " tileLeds"}, expLeds, tileLeds);
		checkValue({testName, " firstColor"}, modelFirstColor, firstColor);
		// a second tile is only face up during the hold delay
		checkValue({testName, " secondColor"}, NoColor, secondColor);
		checkValue({testName, " score"}, modelScore, score);
		checkValue({testName, " gameOver"}, modelPhase == GameOver, gameOver);
	endtask

	task automatic clearModel(input logic [2:0] phase);
		modelMatched = '0;
		modelFirstHeld = 1'b0;
		modelFirstIdx = 0;
		modelFirstColor = NoColor;
		modelScore = '0;
		modelPhase = phase;
	endtask

	task automatic applyModelByte(input logic [7:0] code);
		int idx;
		idx = -1;
		modelRevealColor = NoColor;
		for (int i = 0; i < TileCount; i++)
		begin
			if (code == KeyCodes[i])
				idx = i;
		end
		if (modelBreak)
			modelBreak = 1'b0;
		else if (code == BreakCode)
			modelBreak = 1'b1;
		else if (idx >= 0 && !modelMatched[idx])
		begin
			if (modelPhase == Idle)
			begin
				modelFirstIdx = idx;
				modelFirstHeld = 1'b1;
				modelFirstColor = TileColors[idx];
				modelPhase = OneTile;
			end
			else if (modelPhase == OneTile && idx != modelFirstIdx)
			begin
				modelRevealColor = TileColors[idx];
				// the pair resolves well inside the settle window
				modelScore++;
				if (TileColors[modelFirstIdx] == TileColors[idx])
				begin
					modelMatched[modelFirstIdx] = 1'b1;
					modelMatched[idx] = 1'b1;
				end
				modelFirstHeld = 1'b0;
				modelFirstColor = NoColor;
				modelPhase = (&modelMatched) ? GameOver : Idle;
			end
		end
	endtask

	task automatic sendByte(input string testName, input logic [7:0] code);
		@(negedge Clock);
		keyCode = code;
		keyStrobe = 1'b1;
		@(negedge Clock);
		keyStrobe = 1'b0;
		// a second pick shows its color two edges after the strobe
		@(negedge Clock);
		applyModelByte(code);
		checkValue({testName, " revealed color"}, modelRevealColor, secondColor);
		repeat (SettleCycles - 1) @(negedge Clock);
		compareOutputs(testName);
	endtask

	task automatic pulseQuit(input string testName);
		@(negedge Clock);
		quit = 1'b1;
		@(negedge Clock);
		quit = 1'b0;
		repeat (SettleCycles) @(negedge Clock);
		clearModel(gameEnable ? Idle : NotInGame);
		compareOutputs(testName);
	endtask

	task automatic setEnable(input string testName, input logic value);
		@(negedge Clock);
		gameEnable = value;
		repeat (SettleCycles) @(negedge Clock);
		clearModel(value ? Idle : NotInGame);
		compareOutputs(testName);
	endtask

	initial
	begin
		#(WatchdogNs);
		$display("timeout: the run went on longer than all steps should take");
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		int kind;
		int tile;
		logic [7:0] code;
		rstN = 1'b0;
		gameEnable = 1'b0;
		quit = 1'b0;
		keyCode = 8'h00;
		keyStrobe = 1'b0;
		modelBreak = 1'b0;
		modelRevealColor = NoColor;
		clearModel(NotInGame);
		repeat (2) @(negedge Clock);
		rstN = 1'b1;
		compareOutputs("reset");
		setEnable("enable", 1'b1);

		sendByte("unknown code", 8'h55);
		sendByte("break prefix", BreakCode);
		sendByte("released key", KeyCodes[0]);
		sendByte("first pick", KeyCodes[0]);
		checkValue("first pick color", 32'h3, firstColor);
		sendByte("same tile again", KeyCodes[0]);
		sendByte("mismatch", KeyCodes[1]);
		checkValue("score after mismatch", 32'h1, score);
		sendByte("first of pair", KeyCodes[0]);
		sendByte("matching pair", KeyCodes[9]);
		sendByte("matched first pick", KeyCodes[9]);
		sendByte("first pick", KeyCodes[2]);
		sendByte("matched second pick", KeyCodes[0]);
		sendByte("second pick", KeyCodes[3]);

		// remaining pairs fill the board
		sendByte("pair 4 8", KeyCodes[4]);
		sendByte("pair 4 8", KeyCodes[8]);
		sendByte("pair 1 6", KeyCodes[1]);
		sendByte("pair 1 6", KeyCodes[6]);
		sendByte("pair 5 7", KeyCodes[5]);
		sendByte("pair 5 7", KeyCodes[7]);
		checkValue("board full", 32'h3FF, tileLeds);
		checkValue("game over", 32'h1, gameOver);
		sendByte("key after game over", KeyCodes[1]);

		pulseQuit("quit");
		setEnable("enable low", 1'b0);
		sendByte("key while disabled", KeyCodes[4]);
		setEnable("enable again", 1'b1);
		sendByte("restart pick", KeyCodes[4]);
		sendByte("restart pair", KeyCodes[8]);
		pulseQuit("quit after restart");

		for (int round = 0; round < RandomRounds; round++)
		begin
			kind = {$random(seed)} % 32;
			if (kind < 24)
			begin
				tile = {$random(seed)} % TileCount;
				sendByte("random pick", KeyCodes[tile]);
			end
			else if (kind < 27)
			begin
				code = $random(seed);
				sendByte("random byte", code);
			end
			else if (kind < 30)
			begin
				tile = {$random(seed)} % TileCount;
				sendByte("random break", BreakCode);
				sendByte("random release", KeyCodes[tile]);
			end
			else if (kind == 30)
				pulseQuit("random quit");
			else
			begin
				setEnable("random disable", 1'b0);
				setEnable("random enable", 1'b1);
			end
		end

		$display("all tests passed");
		$finish;
	end

endmodule

//--- tileBoard.sv
`timescale 1ns/1ps

module tileBoard import gamePkg::*; (
	input  logic Clock,
	input  logic rstN,
	input  logic pickValid,
	input  logic [TileIdxW-1:0] pickIdx,
	boardCtrlIf.board boardBus,
	output logic [TileCount-1:0] tileLeds,
	output logic [ColorW-1:0] firstColor,
	output logic [ColorW-1:0] secondColor,
	output logic [ScoreW-1:0] score
);

	logic [TileCount-1:0] matched;
	logic [TileCount-1:0] heldMask;
	logic [TileIdxW-1:0] firstIdx;
	logic [TileIdxW-1:0] secondIdx;
	logic firstHeld;
	logic secondHeld;
	logic pickFree;
	logic acceptFirst;
	logic acceptSecond;

	// a real tile that is not matched yet
	assign pickFree = (pickIdx < TileCount) && !matched[pickIdx];

	assign acceptFirst = pickValid && boardBus.takeFirst && pickFree && !firstHeld;

	assign acceptSecond = pickValid && boardBus.takeSecond && pickFree && firstHeld
		&& !secondHeld && (pickIdx != firstIdx);

	always_ff @(posedge Clock)
	begin
		if (!rstN || boardBus.clearAll)
		begin
			matched <= '0;
			score <= '0;
			firstHeld <= 1'b0;
			secondHeld <= 1'b0;
			firstColor <= NoColor;
			secondColor <= NoColor;
			boardBus.firstTaken <= 1'b0;
			boardBus.secondTaken <= 1'b0;
		end
		else
		begin
			boardBus.firstTaken <= acceptFirst;
			boardBus.secondTaken <= acceptSecond;
			if (boardBus.resolve && secondHeld)
			begin
				score <= score + 1'b1;
				if (firstColor == secondColor)
				begin
					matched[firstIdx] <= 1'b1;
					matched[secondIdx] <= 1'b1;
				end
				// both tiles go back to the idle look either way
				firstHeld <= 1'b0;
				secondHeld <= 1'b0;
				firstColor <= NoColor;
				secondColor <= NoColor;
			end
			else
			begin
				if (acceptFirst)
				begin
					firstHeld <= 1'b1;
					firstColor <= TileColors[pickIdx];
				end
				if (acceptSecond)
				begin
					secondHeld <= 1'b1;
					secondColor <= TileColors[pickIdx];
				end
			end
		end
	end

	always_ff @(posedge Clock)
	begin
		if (acceptFirst)
			firstIdx <= pickIdx;
		if (acceptSecond)
			secondIdx <= pickIdx;
	end

	// face-up tiles light up on top of the matched ones
	always_comb
	begin
		heldMask = '0;
		if (firstHeld)
			heldMask[firstIdx] = 1'b1;
		if (secondHeld)
			heldMask[secondIdx] = 1'b1;
	end

	assign tileLeds = matched | heldMask;
	assign boardBus.allMatched = &matched;

	distinctPair: assert property (
		@(posedge Clock) disable iff (!rstN)
		secondHeld |-> firstHeld && (secondIdx != firstIdx)
	);

endmodule

//--- vlog.f
gamePkg.sv
boardCtrlIf.sv
keyDecoder.sv
revealTimer.sv
tileBoard.sv
gameControl.sv
memoryGameTop.sv
tbMemoryGame.sv
